//--- Bender.yml
package:
  name: mole_game

sources:
  - rtl/mole_game_pkg.sv
  - rtl/game_fsm.sv
  - rtl/target_lfsr.sv
  - rtl/round_timer.sv
  - rtl/hit_scorer.sv
  - rtl/mole_game_top.sv
  - target: simulation
    files:
      - verif/tb_clock_gen.sv
      - verif/mole_game_checker.sv
      - verif/mole_game_tb.sv

//--- mole_game_top.f
rtl/mole_game_pkg.sv
rtl/game_fsm.sv
rtl/target_lfsr.sv
rtl/round_timer.sv
rtl/hit_scorer.sv
rtl/mole_game_top.sv
verif/tb_clock_gen.sv
verif/mole_game_checker.sv
verif/mole_game_tb.sv

//--- rtl/game_fsm.sv
`timescale 1ns/1ps

module game_fsm (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start,       // level from the start key
    input  mole_game_pkg::box_addr_t  box_address,
    input  logic                      time_up,
    output logic                      clear_round, // one cycle, new round setup
    output logic                      game_active,
    output logic                      hit_strobe,  // one cycle per new hit
    output logic                      game_over    // one cycle at the end
);
    import mole_game_pkg::*;

    game_state_t state_q;
    game_state_t state_d;
    logic        addr_seen_q;  // address was nonzero at the previous edge
    logic        addr_nonzero;
    logic        new_hit;

    assign addr_nonzero = (box_address != '0);
    assign new_hit      = addr_nonzero && !addr_seen_q; // rising hit only

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q     <= S_RESET;
            addr_seen_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            addr_seen_q <= addr_nonzero; // sampled in every state
        end
    end

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            S_RESET: begin
                state_d = S_LOBBY;
            end
            S_LOBBY: begin
                if (start) begin
                    state_d = S_START_GAME;
                end
            end
            S_START_GAME: begin
                state_d = S_ACTIVE_GAME; // timer and scorer set up this cycle
            end
            S_ACTIVE_GAME: begin
                if (time_up) begin
                    state_d = S_GAME_OVER;  // end of round beats a late hit
                end else if (new_hit) begin
                    state_d = S_HIT_DETECTED;
                end
            end
            S_HIT_DETECTED: begin
                // a second hit here is dropped
                if (time_up) begin
                    state_d = S_GAME_OVER;
                end else begin
                    state_d = S_ACTIVE_GAME;
                end
            end
            S_GAME_OVER: begin
                state_d = S_LOBBY; // final score stays on the display
            end
            default: begin
                state_d = S_LOBBY;
            end
        endcase
    end

    // outputs straight from the state
    assign clear_round = (state_q == S_START_GAME);
    assign game_active = (state_q == S_ACTIVE_GAME) || (state_q == S_HIT_DETECTED);
    assign hit_strobe  = (state_q == S_HIT_DETECTED);
    assign game_over   = (state_q == S_GAME_OVER);

endmodule

//--- rtl/hit_scorer.sv
`timescale 1ns/1ps

module hit_scorer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      clear_round,
    input  logic                      hit_strobe,  // high the cycle after the hit
    input  mole_game_pkg::box_addr_t  box_address,
    input  mole_game_pkg::box_addr_t  target,
    output mole_game_pkg::score_t     score,
    output logic                      correct      // one cycle per scored hit
);
    import mole_game_pkg::*;

    box_addr_t hit_addr_q; // address one edge back, lines up with hit_strobe
    logic      match;

    // the player may release the box before the strobe, so compare the
    // address seen at the edge where the hit was detected
    always_ff @(posedge clk) begin
        hit_addr_q <= box_address;
    end

    assign match = hit_strobe && (hit_addr_q == target);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            score   <= '0;
            correct <= 1'b0;
        end else begin
            correct <= match;  // wrong box leaves everything alone
            if (clear_round) begin
                score <= '0;
            end else if (match && (score != '1)) begin
                score <= score + 1'b1; // stop at 2047
            end
        end
    end

endmodule

//--- rtl/mole_game_pkg.sv
package mole_game_pkg;

    // sensor board box number, zero means no box was hit
    typedef logic [3:0] box_addr_t;

    typedef logic [10:0] score_t;     // saturates at 2047
    typedef logic [5:0]  seconds_t;   // seconds left in the round
    typedef logic [1:0]  difficulty_t;

    // controller states, same flow as the board firmware
    typedef enum logic [2:0] {
        S_RESET,
        S_LOBBY,
        S_START_GAME,
        S_ACTIVE_GAME,
        S_HIT_DETECTED,
        S_GAME_OVER
    } game_state_t;

    // round length per difficulty, index 0 is the easiest
    localparam seconds_t [3:0] ROUND_SECONDS = {6'd20, 6'd30, 6'd45, 6'd60};

    // target generator, x^4 + x^3 + 1 walks all 15 nonzero values
    localparam box_addr_t LFSR_SEED = 4'b0001;
    localparam box_addr_t LFSR_TAPS = 4'b1100;   // bits 3 and 2 feed back

    // 50 MHz board clock
    localparam int CYCLES_PER_SECOND_DEFAULT = 50_000_000;

endpackage

//--- rtl/mole_game_top.sv
`timescale 1ns/1ps

module mole_game_top #(
    parameter int CYCLES_PER_SECOND = mole_game_pkg::CYCLES_PER_SECOND_DEFAULT
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start,
    input  mole_game_pkg::box_addr_t    box_address,  // zero when nothing hit
    input  mole_game_pkg::difficulty_t  difficulty,
    output mole_game_pkg::score_t       score,
    output mole_game_pkg::box_addr_t    target,
    output mole_game_pkg::seconds_t     seconds_left,
    output logic                        game_active,
    output logic                        hit_seen,     // any new hit
    output logic                        correct_hit,
    output logic                        game_over
);

    logic clear_round;
    logic hit_strobe;
    logic time_up;
    logic lfsr_load;

    // new target at round start and after each scored hit
    assign lfsr_load = clear_round | correct_hit;
    assign hit_seen  = hit_strobe;

    game_fsm i_fsm (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .box_address (box_address),
        .time_up     (time_up),
        .clear_round (clear_round),
        .game_active (game_active),
        .hit_strobe  (hit_strobe),
        .game_over   (game_over)
    );

    target_lfsr i_lfsr (
        .clk    (clk),
        .reset  (reset),
        .load   (lfsr_load),
        .target (target)
    );

    round_timer #(
        .CYCLES_PER_SECOND (CYCLES_PER_SECOND)
    ) i_timer (
        .clk          (clk),
        .reset        (reset),
        .clear_round  (clear_round),
        .game_active  (game_active),  // also counts through hit detected
        .difficulty   (difficulty),
        .seconds_left (seconds_left),
        .time_up      (time_up)
    );

    hit_scorer i_scorer (
        .clk         (clk),
        .reset       (reset),
        .clear_round (clear_round),
        .hit_strobe  (hit_strobe),
        .box_address (box_address),
        .target      (target),
        .score       (score),
        .correct     (correct_hit)
    );

endmodule

//--- rtl/round_timer.sv
`timescale 1ns/1ps

module round_timer #(
    parameter int CYCLES_PER_SECOND = mole_game_pkg::CYCLES_PER_SECOND_DEFAULT
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        clear_round,
    input  logic                        game_active,
    input  mole_game_pkg::difficulty_t  difficulty,
    output mole_game_pkg::seconds_t     seconds_left,
    output logic                        time_up
);
    import mole_game_pkg::*;

    // one spare bit so CYCLES_PER_SECOND = 1 still gives a legal width
    localparam int PRESCALE_W = $clog2(CYCLES_PER_SECOND + 1);

    logic [PRESCALE_W-1:0] prescale_q;
    logic                  second_tick;

    assign second_tick = game_active &&
                         (prescale_q == PRESCALE_W'(CYCLES_PER_SECOND - 1));

    // prescaler, runs only while the round is live
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prescale_q <= '0;
        end else if (clear_round) begin
            prescale_q <= '0;
        end else if (second_tick) begin
            prescale_q <= '0;                  // wrap once per second
        end else if (game_active) begin
            prescale_q <= prescale_q + 1'b1;
        end
    end

    // countdown
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            seconds_left <= '0;
        end else if (clear_round) begin
            // difficulty is captured here as its round length
            seconds_left <= ROUND_SECONDS[difficulty];
        end else if (second_tick && (seconds_left != '0)) begin
            seconds_left <= seconds_left - 1'b1;
        end
    end

    // held until the controller leaves the active states
    assign time_up = game_active && (seconds_left == '0);

endmodule

//--- rtl/target_lfsr.sv
`timescale 1ns/1ps

module target_lfsr (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      load,   // round start or correct hit
    output mole_game_pkg::box_addr_t  target
);
    import mole_game_pkg::*;

    box_addr_t lfsr_q;
    logic      feedback;

    // fibonacci form, xor of the tapped bits shifts in at the bottom
    assign feedback = ^(lfsr_q & LFSR_TAPS);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr_q <= LFSR_SEED;
            target <= '0;  // no target before the first round
        end else begin
            lfsr_q <= {lfsr_q[2:0], feedback}; // free running, never zero
            if (load) begin
                target <= lfsr_q; // value before this edge's step
            end
        end
    end

endmodule

//--- verif/mole_game_checker.sv
`timescale 1ns/1ps

module mole_game_checker #(
    parameter int CYCLES_PER_SECOND = 8
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start,
    input  mole_game_pkg::box_addr_t    box_address,
    input  mole_game_pkg::difficulty_t  difficulty,
    input  mole_game_pkg::score_t       score,
    input  mole_game_pkg::box_addr_t    target,
    input  mole_game_pkg::seconds_t     seconds_left,
    input  logic                        game_active,
    input  logic                        hit_seen,
    input  logic                        correct_hit,
    input  logic                        game_over,
    output int                          error_count,
    output int                          check_count,
    output int                          correct_count,   // scored hits seen
    output int                          wrong_count,     // hits on the wrong box
    output int                          game_count,      // finished rounds
    output logic [3:0]                  difficulties_seen
);
    import mole_game_pkg::*;

    game_state_t m_state;
    logic        m_addr_seen;  // previous sample of a nonzero address
    box_addr_t   m_hit_addr;   // address one edge back
    box_addr_t   m_lfsr;
    box_addr_t   m_target;
    int          m_prescale;
    seconds_t    m_seconds;
    score_t      m_score;
    logic        m_correct;
    logic        armed = 1'b0; // no compare before the first clock edge
    logic        active_q = 1'b0;  // dut game_active at the previous compare
    logic        m_clear, m_active, m_hit, m_over, m_time_up, m_tick, m_match, m_new_hit;

    // model outputs decoded from the model state
    assign m_clear   = (m_state == S_START_GAME);
    assign m_active  = (m_state == S_ACTIVE_GAME) || (m_state == S_HIT_DETECTED);
    assign m_hit     = (m_state == S_HIT_DETECTED);
    assign m_over    = (m_state == S_GAME_OVER);
    assign m_time_up = m_active && (m_seconds == 0);
    assign m_tick    = m_active && (m_prescale == CYCLES_PER_SECOND - 1);
    assign m_match   = m_hit && (m_hit_addr == m_target);
    assign m_new_hit = (box_address != 0) && !m_addr_seen;

    // one shift of x^4+x^3+1, feedback collected tap by tap
    function automatic box_addr_t lfsr_next(input box_addr_t v);
        logic fb;
        int   i;
        fb = 1'b0;
        for (i = 0; i < 4; i++) begin
            if (LFSR_TAPS[i]) fb = fb ^ v[i];
        end
        return {v[2:0], fb};
    endfunction

    task automatic check_value(input string name, input logic [10:0] expected,
                               input logic [10:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR %0t: %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    initial begin
        error_count = 0;
        check_count = 0;
        correct_count = 0;
        wrong_count = 0;
        game_count = 0;
        difficulties_seen = 4'b0000;
    end

    always @(posedge clk) begin
        m_hit_addr <= box_address;  // no reset on this register
        armed      <= 1'b1;
    end

    // cycle model of the game
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            m_state <= S_RESET;
            m_addr_seen <= 1'b0;
            m_lfsr <= LFSR_SEED;
            m_target <= '0;
            m_prescale <= 0;
            m_seconds <= '0;
            m_score <= '0;
            m_correct <= 1'b0;
        end else begin
            m_addr_seen <= (box_address != 0);
            m_lfsr <= lfsr_next(m_lfsr);  // steps every clock
            if (m_clear || m_correct) m_target <= m_lfsr;  // pre-step value
            case (m_state)
                S_RESET:        m_state <= S_LOBBY;
                S_LOBBY:        if (start) m_state <= S_START_GAME;
                S_START_GAME:   m_state <= S_ACTIVE_GAME;
                S_ACTIVE_GAME: begin
                    if (m_time_up) m_state <= S_GAME_OVER;   // time beats a hit
                    else if (m_new_hit) m_state <= S_HIT_DETECTED;
                end
                S_HIT_DETECTED: m_state <= m_time_up ? S_GAME_OVER : S_ACTIVE_GAME;
                default:        m_state <= S_LOBBY;
            endcase
            if (m_clear || m_tick) m_prescale <= 0;
            else if (m_active) m_prescale <= m_prescale + 1;
            if (m_clear) m_seconds <= ROUND_SECONDS[difficulty];
            else if (m_tick && m_seconds != 0) m_seconds <= m_seconds - 1'b1;
            m_correct <= m_match;
            if (m_clear) m_score <= '0;
            else if (m_match && m_score != 11'd2047) m_score <= m_score + 1'b1;
        end
    end

    // compare in the middle of the cycle, outputs are settled here
    always @(negedge clk) begin
        if (armed) begin
            check_value("score", m_score, score);
            check_value("target", m_target, target);
            check_value("seconds_left", m_seconds, seconds_left);
            check_value("game_active", m_active, game_active);
            check_value("hit_seen", m_hit, hit_seen);
            check_value("correct_hit", m_correct, correct_hit);
            check_value("game_over", m_over, game_over);
            if (m_over) game_count++;
            if (m_correct) correct_count++;
            if (m_hit && !m_match) wrong_count++;
            // round length the dut loaded, seen on its first active cycle
            if (game_active && !active_q) begin
                for (int d = 0; d < 4; d++) begin
                    if (seconds_left == ROUND_SECONDS[d]) difficulties_seen[d] = 1'b1;
                end
            end
            active_q = game_active;
        end
    end

endmodule

//--- verif/mole_game_tb.sv
`timescale 1ns/1ps

module mole_game_tb;
    import mole_game_pkg::*;

    localparam int CPS = 8;
    localparam int NUM_GAMES = 12;
    localparam int TIMEOUT_CYCLES = 2 * NUM_GAMES * (60 * CPS + 40);

    logic        clk, reset, start, game_active, hit_seen, correct_hit, game_over;
    box_addr_t   box_address, target;
    difficulty_t difficulty;
    score_t      score;
    seconds_t    seconds_left;
    logic [3:0]  difficulties_seen;
    int          error_count, check_count, correct_count, wrong_count, game_count;
    int          seed = 56;
    int          tb_errors = 0;
    int          cycle_count = 0;
    box_addr_t   pattern[$];  // box values still to drive, one per cycle

    tb_clock_gen i_clk_gen (.clk(clk), .reset(reset));

    mole_game_top #(.CYCLES_PER_SECOND(CPS)) i_dut (
        .clk(clk), .reset(reset), .start(start), .box_address(box_address),
        .difficulty(difficulty), .score(score), .target(target),
        .seconds_left(seconds_left), .game_active(game_active), .hit_seen(hit_seen),
        .correct_hit(correct_hit), .game_over(game_over)
    );

    mole_game_checker #(.CYCLES_PER_SECOND(CPS)) i_checker (
        .clk(clk), .reset(reset), .start(start), .box_address(box_address),
        .difficulty(difficulty), .score(score), .target(target),
        .seconds_left(seconds_left), .game_active(game_active), .hit_seen(hit_seen),
        .correct_hit(correct_hit), .game_over(game_over), .error_count(error_count),
        .check_count(check_count), .correct_count(correct_count),
        .wrong_count(wrong_count), .game_count(game_count),
        .difficulties_seen(difficulties_seen)
    );

    task automatic next_cycle();
        @(posedge clk);
        #1;  // inputs change just after the edge
    endtask

    function automatic int random_range(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic box_addr_t random_box();
        return box_addr_t'(random_range(15) + 1);  // never zero
    endfunction

    // one player action, queued as a run of box values
    task automatic queue_action();
        box_addr_t a;
        a = random_box();
        case (random_range(8))
            0, 1, 2, 3: begin
                pattern.push_back(target);  // aim at the live target
                repeat (3 + random_range(2)) pattern.push_back('0); // new target settles
            end
            4: begin
                pattern.push_back(a);
                pattern.push_back('0);
            end
            5: begin
                repeat (3 + random_range(4)) pattern.push_back(a);  // held box
                pattern.push_back('0);
            end
            6: begin
                pattern.push_back(a);
                pattern.push_back(random_box());  // lands in hit detected
                pattern.push_back('0);
            end
            default: begin
                start = 1'b1;  // stray press while the round runs
                difficulty = difficulty_t'(random_range(4));
                pattern.push_back('0);
            end
        endcase
    endtask

    task automatic play_game(input int idx);
        int waited;
        repeat (3 + random_range(6)) begin
            next_cycle();
            box_address = random_range(2) ? random_box() : '0;  // lobby ignores these
        end
        next_cycle();
        box_address = '0;
        difficulty = (idx < 4) ? difficulty_t'(idx) : difficulty_t'(random_range(4));
        start = 1'b1;
        repeat (1 + random_range(2)) next_cycle();
        start = 1'b0;
        waited = 0;
        while (!game_active && waited < 8) begin
            next_cycle();
            waited++;
        end
        if (!game_active) begin
            $display("game %0d did not start after the start press", idx);
            tb_errors++;
        end else begin
            pattern.delete();
            while (!game_over) begin
                if (pattern.size() == 0) queue_action();
                box_address = pattern.pop_front();
                next_cycle();
                start = 1'b0;
            end
            box_address = '0;
        end
    endtask

    task automatic finish_run();
        int total;
        total = error_count + tb_errors;
        $display("errors=%0d checks=%0d", total, check_count);
        if (total == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    initial begin
        start = 1'b0;
        box_address = '0;
        difficulty = '0;
        @(negedge reset);
        for (int g = 0; g < NUM_GAMES; g++) play_game(g);
        repeat (4) next_cycle();
        if (game_count != NUM_GAMES) begin
            $display("only %0d of %0d games came to an end", game_count, NUM_GAMES);
            tb_errors++;
        end
        if (correct_count == 0 || wrong_count == 0) begin
            $display("the games had no correct hit or no wrong hit");
            tb_errors++;
        end
        if (difficulties_seen != 4'hf) begin
            $display("not every difficulty was played, mask %b", difficulties_seen);
            tb_errors++;
        end
        finish_run();
    end

    // run limit, worst case round length with a margin
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            tb_errors++;
            finish_run();
        end
    end

endmodule

//--- verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;         // released just after an edge, like the stimulus
    end

endmodule
